// File: common/sd_proto_pkg.sv
package sd_proto_pkg;

    // ========================================================================
    // Command and response frame layout
    // ========================================================================

    // Whole frame on the CMD line, start bit first
    localparam int cmd_frame_bits = 48;

    // Field widths
    localparam int cmd_index_bits = 6;
    localparam int cmd_arg_bits   = 32;
    localparam int crc7_bits      = 7;

    // Leading bits protected by the CRC: start, direction, index, argument
    localparam int crc_covered_bits = 40;

    // Bit positions counted from the end of the frame
    localparam int end_bit_pos   = 0;
    localparam int crc_field_lsb = 1;

    // ========================================================================
    // Fixed bit values
    // ========================================================================

    localparam logic start_bit_val = 1'b0;
    localparam logic end_bit_val   = 1'b1;

    // Host to card; responses from the card carry 0 here
    localparam logic host_dir_bit = 1'b1;

    // x^7 + x^3 + 1, the x^7 term is implicit
    localparam logic [crc7_bits-1:0] crc7_poly = 7'h09;

endpackage

// File: common/sd_host_pkg.sv
package sd_host_pkg;

    // Cycles the receiver waits for a start bit before giving up
    localparam int resp_timeout_cycles = 64;

    // Turnaround after the host releases the CMD line
    localparam int resp_guard_cycles = 2;

    // Bit counter of the serializer
    localparam int frame_cnt_bits = $clog2(sd_proto_pkg::cmd_frame_bits);
    typedef logic [frame_cnt_bits-1:0] frame_cnt_t;

    // Receiver counter covers guard, timeout window and frame capture
    localparam int rx_cnt_bits =
        (resp_timeout_cycles > sd_proto_pkg::cmd_frame_bits) ?
        $clog2(resp_timeout_cycles) : $clog2(sd_proto_pkg::cmd_frame_bits);
    typedef logic [rx_cnt_bits-1:0] rx_cnt_t;

    // Sequencer FSM states
    typedef enum logic [1:0] {
        seq_idle,
        seq_sending,
        seq_receiving,
        seq_acking
    } seq_state_t;

endpackage

// File: source/sd_crc7.sv
`timescale 1ns/1ps

module sd_crc7 (
    input  logic                                clk_fast,
    input  logic                                arst_n,
    input  logic                                clear,
    input  logic                                en,
    input  logic                                din,
    output logic [sd_proto_pkg::crc7_bits-1:0]  crc
);

    logic feedback;

    // Incoming bit against the top of the register
    assign feedback = din ^ crc[sd_proto_pkg::crc7_bits-1];

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            crc <= {crc[sd_proto_pkg::crc7_bits-2:0], 1'b0}
                 ^ (feedback ? sd_proto_pkg::crc7_poly : '0);
        end
    end

endmodule

// File: sd_cmd/sd_cmd_sequencer.sv
`timescale 1ns/1ps

module sd_cmd_sequencer (
    input  logic clk_fast,
    input  logic arst_n,
    input  logic req,
    input  logic resp_expected,
    input  logic sent,
    input  logic done,
    output logic ack,
    output logic start,
    output logic listen
);

    sd_host_pkg::seq_state_t state;

    // One cycle between taking the request and starting the serializer
    logic accepted;

    // ========================================================================
    // Request FSM
    // ========================================================================

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state    <= sd_host_pkg::seq_idle;
            accepted <= 1'b0;
            start    <= 1'b0;
            listen   <= 1'b0;
            ack      <= 1'b0;
        end else begin
            // Pulses by default
            accepted <= 1'b0;
            start    <= accepted;
            listen   <= 1'b0;

            case (state)
                sd_host_pkg::seq_idle: begin
                    if (req && !ack) begin
                        accepted <= 1'b1;
                        state    <= sd_host_pkg::seq_sending;
                    end
                end
                sd_host_pkg::seq_sending: begin
                    if (sent) begin
                        if (resp_expected) begin
                            listen <= 1'b1;
                            state  <= sd_host_pkg::seq_receiving;
                        end else begin
                            ack   <= 1'b1;
                            state <= sd_host_pkg::seq_acking;
                        end
                    end
                end
                sd_host_pkg::seq_receiving: begin
                    if (done) begin
                        ack   <= 1'b1;
                        state <= sd_host_pkg::seq_acking;
                    end
                end
                sd_host_pkg::seq_acking: begin
                    // Results stay valid until the requester drops req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= sd_host_pkg::seq_idle;
                    end
                end
                default: begin
                    state <= sd_host_pkg::seq_idle;
                end
            endcase
        end
    end

endmodule

// File: sd_cmd/sd_cmd_serializer.sv
`timescale 1ns/1ps

module sd_cmd_serializer (
    input  logic                                    clk_fast,
    input  logic                                    arst_n,
    input  logic                                    start,
    input  logic [sd_proto_pkg::cmd_index_bits-1:0] cmd_index,
    input  logic [sd_proto_pkg::cmd_arg_bits-1:0]   cmd_arg,
    output logic                                    sd_cmd_out,
    output logic                                    sd_cmd_oe,
    output logic                                    sent
);

    logic [sd_proto_pkg::cmd_frame_bits-1:0] shift_reg;
    sd_host_pkg::frame_cnt_t                 bit_cnt;
    logic [sd_proto_pkg::crc7_bits-1:0]      crc;
    logic                                    crc_phase;
    logic                                    crc_en;
    logic                                    tx_bit;

    // CRC slot follows the covered bits
    assign crc_phase = bit_cnt >= sd_host_pkg::frame_cnt_t'(sd_proto_pkg::crc_covered_bits)
                    && bit_cnt < sd_host_pkg::frame_cnt_t'(
                           sd_proto_pkg::crc_covered_bits + sd_proto_pkg::crc7_bits);

    // Feeding the CRC its own top bit shifts it out unchanged
    assign tx_bit = crc_phase ? crc[sd_proto_pkg::crc7_bits-1] : shift_reg[$high(shift_reg)];
    assign crc_en = sd_cmd_oe && bit_cnt < sd_host_pkg::frame_cnt_t'(
                        sd_proto_pkg::crc_covered_bits + sd_proto_pkg::crc7_bits);

    // Line idles high when released
    assign sd_cmd_out = sd_cmd_oe ? tx_bit : 1'b1;

    sd_crc7 i_crc (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .clear    (start),
        .en       (crc_en),
        .din      (tx_bit),
        .crc      (crc)
    );

    // ========================================================================
    // Frame shift register
    // ========================================================================

    always_ff @(posedge clk_fast) begin
        if (start) begin
            shift_reg <= {sd_proto_pkg::start_bit_val, sd_proto_pkg::host_dir_bit,
                          cmd_index, cmd_arg, {sd_proto_pkg::crc7_bits{1'b0}},
                          sd_proto_pkg::end_bit_val};
        end else if (sd_cmd_oe) begin
            shift_reg <= {shift_reg[$high(shift_reg)-1:0], 1'b1};
        end
    end

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            sd_cmd_oe <= 1'b0;
            bit_cnt   <= '0;
            sent      <= 1'b0;
        end else begin
            sent <= sd_cmd_oe
                 && bit_cnt == sd_host_pkg::frame_cnt_t'(sd_proto_pkg::cmd_frame_bits - 2);
            if (start) begin
                sd_cmd_oe <= 1'b1;
                bit_cnt   <= '0;
            end else if (sd_cmd_oe) begin
                bit_cnt <= bit_cnt + 1'b1;
                // Release after the end bit
                if (bit_cnt == sd_host_pkg::frame_cnt_t'(sd_proto_pkg::cmd_frame_bits - 1)) begin
                    sd_cmd_oe <= 1'b0;
                end
            end
        end
    end

endmodule

// File: sd_cmd/sd_resp_receiver.sv
`timescale 1ns/1ps

module sd_resp_receiver (
    input  logic                                    clk_fast,
    input  logic                                    arst_n,
    input  logic                                    listen,
    input  logic                                    sd_cmd_in,
    output logic [sd_proto_pkg::cmd_frame_bits-1:0] resp,
    output logic                                    crc_err,
    output logic                                    timeout,
    output logic                                    done
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_guard,
        rx_hunt,
        rx_capture
    } rx_phase_t;

    rx_phase_t                               phase;
    sd_host_pkg::rx_cnt_t                    cnt;
    logic [sd_proto_pkg::crc7_bits-1:0]      crc;
    logic                                    crc_en;
    logic [sd_proto_pkg::cmd_frame_bits-1:0] rx_frame;

    // Frame as it stands once the current bit is in
    assign rx_frame = {resp[$high(resp)-1:0], sd_cmd_in};

    // Start bit plus the covered bits behind it
    assign crc_en = (phase == rx_hunt && sd_cmd_in == sd_proto_pkg::start_bit_val)
                 || (phase == rx_capture
                     && cnt < sd_host_pkg::rx_cnt_t'(sd_proto_pkg::crc_covered_bits));

    sd_crc7 i_crc (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .clear    (listen),
        .en       (crc_en),
        .din      (sd_cmd_in),
        .crc      (crc)
    );

    // Response shifts straight into the output register
    always_ff @(posedge clk_fast) begin
        if (crc_en || phase == rx_capture) begin
            resp <= rx_frame;
        end
    end

    // ========================================================================
    // Guard, start bit search and capture
    // ========================================================================

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= rx_idle;
            cnt     <= '0;
            crc_err <= 1'b0;
            timeout <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            cnt  <= cnt + 1'b1;
            if (listen) begin
                phase   <= rx_guard;
                cnt     <= '0;
                crc_err <= 1'b0;
                timeout <= 1'b0;
            end else begin
                case (phase)
                    rx_guard: begin
                        if (cnt == sd_host_pkg::rx_cnt_t'(sd_host_pkg::resp_guard_cycles - 1)) begin
                            phase <= rx_hunt;
                            cnt   <= '0;
                        end
                    end
                    rx_hunt: begin
                        if (sd_cmd_in == sd_proto_pkg::start_bit_val) begin
                            phase <= rx_capture;
                            cnt   <= sd_host_pkg::rx_cnt_t'(1);
                        end else if (cnt == sd_host_pkg::rx_cnt_t'(
                                         sd_host_pkg::resp_timeout_cycles - 1)) begin
                            // Card never answered
                            phase   <= rx_idle;
                            timeout <= 1'b1;
                            done    <= 1'b1;
                        end
                    end
                    rx_capture: begin
                        if (cnt == sd_host_pkg::rx_cnt_t'(sd_proto_pkg::cmd_frame_bits - 1)) begin
                            phase   <= rx_idle;
                            done    <= 1'b1;
                            crc_err <= (rx_frame[sd_proto_pkg::crc_field_lsb +:
                                                 sd_proto_pkg::crc7_bits] != crc)
                                    || (rx_frame[sd_proto_pkg::end_bit_pos]
                                        != sd_proto_pkg::end_bit_val);
                        end
                    end
                    default: begin
                        cnt <= '0;
                    end
                endcase
            end
        end
    end

endmodule

// File: source/sd_cmd_host.sv
`timescale 1ns/1ps

module sd_cmd_host (
    input  logic                                    clk_fast,
    input  logic                                    arst_n,
    input  logic                                    req,
    input  logic [sd_proto_pkg::cmd_index_bits-1:0] cmd_index,
    input  logic [sd_proto_pkg::cmd_arg_bits-1:0]   cmd_arg,
    input  logic                                    resp_expected,
    input  logic                                    sd_cmd_in,
    output logic                                    ack,
    output logic [sd_proto_pkg::cmd_frame_bits-1:0] resp,
    output logic                                    resp_crc_err,
    output logic                                    resp_timeout,
    output logic                                    sd_cmd_out,
    output logic                                    sd_cmd_oe
);

    // Stage handshakes
    logic start;
    logic sent;
    logic listen;
    logic done;

    sd_cmd_sequencer i_sequencer (
        .clk_fast      (clk_fast),
        .arst_n        (arst_n),
        .req           (req),
        .resp_expected (resp_expected),
        .sent          (sent),
        .done          (done),
        .ack           (ack),
        .start         (start),
        .listen        (listen)
    );

    sd_cmd_serializer i_serializer (
        .clk_fast   (clk_fast),
        .arst_n     (arst_n),
        .start      (start),
        .cmd_index  (cmd_index),
        .cmd_arg    (cmd_arg),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sent       (sent)
    );

    sd_resp_receiver i_receiver (
        .clk_fast  (clk_fast),
        .arst_n    (arst_n),
        .listen    (listen),
        .sd_cmd_in (sd_cmd_in),
        .resp      (resp),
        .crc_err   (resp_crc_err),
        .timeout   (resp_timeout),
        .done      (done)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_fast,
    output logic arst_n
);

    // 40 ns period
    initial begin
        clk_fast = 1'b0;
        forever begin
            #20 clk_fast = ~clk_fast;
        end
    end

    // Reset held for 16 cycles, released on a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk_fast);
        arst_n <= 1'b1;
    end

endmodule

// File: dv/sd_cmd_host_checker.sv
`timescale 1ns/1ps

module sd_cmd_host_checker (
    input logic                    clk_fast,
    input logic                    arst_n,
    input logic                    req,
    input logic                    ack,
    input logic                    resp_expected,
    input logic                    listen,
    input logic                    sd_cmd_oe,
    input logic                    sd_cmd_out,
    input sd_host_pkg::seq_state_t seq_state
);

    int unsigned assert_failures = 0;

    // Length of the current run of sd_cmd_oe high
    int oe_run;

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            oe_run <= 0;
        end else begin
            oe_run <= sd_cmd_oe ? oe_run + 1 : 0;
        end
    end

    // ========================================================================
    // Handshake
    // ========================================================================

    ack_needs_req: assert property (@(posedge clk_fast) disable iff (!arst_n)
        $rose(ack) |-> req)
        else begin
            $error("ack rose while req was low");
            assert_failures++;
        end

    ack_drops_after_req: assert property (@(posedge clk_fast) disable iff (!arst_n)
        ack && !req |=> !ack)
        else begin
            $error("ack still high one cycle after req was seen low");
            assert_failures++;
        end

    ack_held_with_req: assert property (@(posedge clk_fast) disable iff (!arst_n)
        ack && req |=> ack)
        else begin
            $error("ack dropped while req was still high");
            assert_failures++;
        end

    listen_only_for_resp: assert property (@(posedge clk_fast) disable iff (!arst_n)
        listen |-> resp_expected)
        else begin
            $error("Receiver started for a command without response");
            assert_failures++;
        end

    // ========================================================================
    // CMD line
    // ========================================================================

    frame_length: assert property (@(posedge clk_fast) disable iff (!arst_n)
        $fell(sd_cmd_oe) |-> oe_run == sd_proto_pkg::cmd_frame_bits)
        else begin
            $error("sd_cmd_oe was not high for exactly %0d cycles",
                   sd_proto_pkg::cmd_frame_bits);
            assert_failures++;
        end

    idle_line_released: assert property (@(posedge clk_fast) disable iff (!arst_n)
        seq_state == sd_host_pkg::seq_idle |-> !sd_cmd_oe)
        else begin
            $error("sd_cmd_oe high while the sequencer is idle");
            assert_failures++;
        end

    released_line_high: assert property (@(posedge clk_fast) disable iff (!arst_n)
        !sd_cmd_oe |-> sd_cmd_out)
        else begin
            $error("sd_cmd_out low while the line is released");
            assert_failures++;
        end

    // No disable here, this one looks at the reset release itself
    quiet_after_reset: assert property (@(posedge clk_fast)
        $rose(arst_n) |-> !ack && !sd_cmd_oe)
        else begin
            $error("ack or sd_cmd_oe high right after reset");
            assert_failures++;
        end

endmodule

bind sd_cmd_host sd_cmd_host_checker i_checker (
    .clk_fast      (clk_fast),
    .arst_n        (arst_n),
    .req           (req),
    .ack           (ack),
    .resp_expected (resp_expected),
    .listen        (listen),
    .sd_cmd_oe     (sd_cmd_oe),
    .sd_cmd_out    (sd_cmd_out),
    .seq_state     (i_sequencer.state)
);

// File: dv/tb_sd_cmd_host.sv
`timescale 1ns/1ps

module tb_sd_cmd_host;

    typedef enum int {
        mode_good,
        mode_bad_crc,
        mode_bad_end,
        mode_silent,
        mode_no_resp
    } card_mode_t;

    logic                                    clk_fast;
    logic                                    arst_n;
    logic                                    req;
    logic [sd_proto_pkg::cmd_index_bits-1:0] cmd_index;
    logic [sd_proto_pkg::cmd_arg_bits-1:0]   cmd_arg;
    logic                                    resp_expected;
    logic                                    sd_cmd_in;
    logic                                    ack;
    logic [sd_proto_pkg::cmd_frame_bits-1:0] resp;
    logic                                    resp_crc_err;
    logic                                    resp_timeout;
    logic                                    sd_cmd_out;
    logic                                    sd_cmd_oe;

    // Card model state, set up by each test before req
    card_mode_t                              card_mode;
    int                                      card_delay;
    logic [sd_proto_pkg::cmd_frame_bits-1:0] card_resp;
    logic [sd_proto_pkg::cmd_frame_bits-1:0] card_frame;
    int                                      frames_seen;

    logic [31:0] rng_state;
    int          cycle_cnt = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tb_clock_gen i_clock_gen (
        .clk_fast (clk_fast),
        .arst_n   (arst_n)
    );

    sd_cmd_host i_dut (
        .clk_fast      (clk_fast),
        .arst_n        (arst_n),
        .req           (req),
        .cmd_index     (cmd_index),
        .cmd_arg       (cmd_arg),
        .resp_expected (resp_expected),
        .sd_cmd_in     (sd_cmd_in),
        .ack           (ack),
        .resp          (resp),
        .resp_crc_err  (resp_crc_err),
        .resp_timeout  (resp_timeout),
        .sd_cmd_out    (sd_cmd_out),
        .sd_cmd_oe     (sd_cmd_oe)
    );

    // ========================================================================
    // Reference models
    // ========================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Polynomial division, MSB first
    function automatic logic [sd_proto_pkg::crc7_bits-1:0] crc7_of(
        input logic [sd_proto_pkg::crc_covered_bits-1:0] bits
    );
        logic [sd_proto_pkg::crc7_bits-1:0] c;
        logic                               fb;
        c = '0;
        for (int i = sd_proto_pkg::crc_covered_bits - 1; i >= 0; i--) begin
            fb = bits[i] ^ c[sd_proto_pkg::crc7_bits-1];
            c  = {c[sd_proto_pkg::crc7_bits-2:0], 1'b0};
            if (fb) begin
                c = c ^ sd_proto_pkg::crc7_poly;
            end
        end
        return c;
    endfunction

    function automatic logic [sd_proto_pkg::cmd_frame_bits-1:0] build_frame(
        input logic                                    dir,
        input logic [sd_proto_pkg::cmd_index_bits-1:0] index,
        input logic [sd_proto_pkg::cmd_arg_bits-1:0]   arg
    );
        logic [sd_proto_pkg::crc_covered_bits-1:0] head;
        head = {sd_proto_pkg::start_bit_val, dir, index, arg};
        return {head, crc7_of(head), sd_proto_pkg::end_bit_val};
    endfunction

    // ========================================================================
    // Card model
    // ========================================================================

    initial begin : card_model
        sd_cmd_in   = 1'b1;
        frames_seen = 0;
        card_frame  = '0;
        forever begin
            @(posedge clk_fast);
            if (sd_cmd_oe) begin
                for (int i = 0; i < sd_proto_pkg::cmd_frame_bits; i++) begin
                    if (i > 0) begin
                        @(posedge clk_fast);
                    end
                    card_frame = {card_frame[sd_proto_pkg::cmd_frame_bits-2:0], sd_cmd_out};
                end
                frames_seen++;
                if (card_mode != mode_silent && card_mode != mode_no_resp) begin
                    repeat (card_delay) @(posedge clk_fast);
                    for (int i = sd_proto_pkg::cmd_frame_bits - 1; i >= 0; i--) begin
                        if (i < sd_proto_pkg::cmd_frame_bits - 1) begin
                            @(posedge clk_fast);
                        end
                        sd_cmd_in <= card_resp[i];
                    end
                    @(posedge clk_fast);
                    sd_cmd_in <= 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Checks and test sequence
    // ========================================================================

    task automatic check_value(input string name, input logic [47:0] expected,
                               input logic [47:0] observed);
        assert (observed === expected) else begin
            $display("Fail at %0d ns: %s expected 0x%0h observed 0x%0h",
                     $time, name, expected, observed);
            error_count++;
        end
    endtask

    task automatic wait_ack(input logic level);
        @(posedge clk_fast);
        while (ack !== level) begin
            @(posedge clk_fast);
        end
    endtask

    task automatic run_test(input string name, input card_mode_t mode);
        logic [31:0]                             rnd;
        logic [sd_proto_pkg::cmd_index_bits-1:0] index;
        logic [sd_proto_pkg::cmd_arg_bits-1:0]   arg;
        logic [sd_proto_pkg::cmd_frame_bits-1:0] exp_cmd;
        int                                      flip_pos;
        int                                      start_cycle;
        int                                      frames_before;
        int                                      errors_before;
        rnd        = next_random();
        index      = rnd[sd_proto_pkg::cmd_index_bits-1:0];
        arg        = next_random();
        exp_cmd    = build_frame(sd_proto_pkg::host_dir_bit, index, arg);
        card_mode  = mode;
        card_delay = 3 + int'(next_random() % 6);
        card_resp  = build_frame(~sd_proto_pkg::host_dir_bit, index, next_random());
        if (mode == mode_bad_crc) begin
            flip_pos = sd_proto_pkg::crc_field_lsb + int'(next_random() % 7);
            card_resp[flip_pos] = ~card_resp[flip_pos];
        end
        if (mode == mode_bad_end) begin
            card_resp[sd_proto_pkg::end_bit_pos] = ~sd_proto_pkg::end_bit_val;
        end
        errors_before = error_count;
        frames_before = frames_seen;

        @(posedge clk_fast);
        req           <= 1'b1;
        cmd_index     <= index;
        cmd_arg       <= arg;
        resp_expected <= (mode != mode_no_resp);
        start_cycle   = cycle_cnt;
        wait_ack(1'b1);

        check_value("command frame", exp_cmd, card_frame);
        assert (frames_seen == frames_before + 1) else begin
            $display("Card saw %0d command frames in test %s instead of one",
                     frames_seen - frames_before, name);
            error_count++;
        end
        if (mode == mode_no_resp) begin
            // Accept, start, the frame itself, then ack
            check_value("ack latency", 48'(2 + sd_proto_pkg::cmd_frame_bits + 1),
                        48'(cycle_cnt - start_cycle - 1));
        end else begin
            check_value("resp_timeout", 48'(mode == mode_silent), 48'(resp_timeout));
            check_value("resp_crc_err",
                        48'(mode == mode_bad_crc || mode == mode_bad_end),
                        48'(resp_crc_err));
            if (mode != mode_silent) begin
                check_value("resp", card_resp, resp);
            end
        end

        req <= 1'b0;
        wait_ack(1'b0);
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, name,
                 (error_count == errors_before) ? "passed" : "failed");
    endtask

    // Budget per test covers frame, turnaround, timeout window and capture
    always @(posedge clk_fast) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 2 * 6 * (51 + 8 + sd_host_pkg::resp_timeout_cycles
                                  + sd_proto_pkg::cmd_frame_bits + 10)) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin : test_sequence
        req           = 1'b0;
        cmd_index     = '0;
        cmd_arg       = '0;
        resp_expected = 1'b0;
        rng_state     = 32'd27976;
        card_mode     = mode_silent;
        card_delay    = 3;
        card_resp     = '1;

        @(posedge arst_n);
        repeat (2) @(posedge clk_fast);

        run_test("good response", mode_good);
        run_test("second good response", mode_good);
        run_test("corrupted crc", mode_bad_crc);
        run_test("cleared end bit", mode_bad_end);
        run_test("missing response", mode_silent);
        run_test("command without response", mode_no_resp);

        error_count += int'(i_dut.i_checker.assert_failures);
        $display("Tests run %0d, passed %0d, failed %0d, checker failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed,
                 i_dut.i_checker.assert_failures);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
common/sd_proto_pkg.sv
common/sd_host_pkg.sv
source/sd_crc7.sv
sd_cmd/sd_cmd_sequencer.sv
sd_cmd/sd_cmd_serializer.sv
sd_cmd/sd_resp_receiver.sv
source/sd_cmd_host.sv
dv/tb_clock_gen.sv
dv/sd_cmd_host_checker.sv
dv/tb_sd_cmd_host.sv

// File: Makefile
# Verilator flow for the SD command-line host

VERILATOR ?= verilator
TOP       ?= tb_sd_cmd_host
RTL_TOP   ?= sd_cmd_host
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

PASS_MSG := Simulation finished: PASS
FAIL_MSG := Simulation finished: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
